//--- logic/reversal_mb_cfg.svh
`ifndef REVERSAL_MB_CFG_SVH
`define REVERSAL_MB_CFG_SVH

// data lanes covered by the result_resp payload
`define REVMB_LANES 16

// pass needs strictly more matching lanes than this
`define REVMB_PASS_LANES 8

// decoded sideband message code width
`define REVMB_MSG_W 4

// counter width for the match count, holds 0..REVMB_LANES
`define REVMB_CNT_W $clog2(`REVMB_LANES + 1)

`endif

//--- logic/reversal_mb_pkg.sv
`include "reversal_mb_cfg.svh"

package reversal_mb_pkg;

    // reversal sideband messages, decoded form
    typedef enum logic [`REVMB_MSG_W-1:0] {
        MSG_NONE             = 'd0, // nothing received / nothing to send
        MSG_INIT_REQ         = 'd1,
        MSG_INIT_RESP        = 'd2,
        MSG_CLEAR_ERROR_REQ  = 'd3,
        MSG_CLEAR_ERROR_RESP = 'd4,
        MSG_RESULT_REQ       = 'd5,
        MSG_RESULT_RESP      = 'd6,
        MSG_DONE_REQ         = 'd7,
        MSG_DONE_RESP        = 'd8
    } sb_msg_e;

    // mainband pattern generator control word
    typedef enum logic [1:0] {
        PG_IDLE       = 2'd0,
        PG_CLEAR_LFSR = 2'd1, // reset lfsr + partner error counters
        PG_PERLANE_ID = 2'd3  // drive per-lane id pattern
    } pg_cw_e;

    // sequencer states
    typedef enum logic [3:0] {
        IDLE,
        WAIT_PARTNER, // partner owns the handshake for now
        INIT_REQ,
        CLEAR_REQ,
        SEND_PATTERN,
        RESULT_REQ,
        RESOLVE,
        DONE_REQ,
        FINISHED
    } seq_state_e;

    // outcome of one lane result evaluation
    typedef enum logic [1:0] {
        V_PASS,
        V_RETRY, // too few lanes, reversal not tried yet
        V_FAIL   // too few lanes after reversal
    } verdict_e;

endpackage

//--- logic/lane_eval_if.sv
`timescale 1ns/10ps

// sequencer <-> lane evaluator
interface lane_eval_if import reversal_mb_pkg::*; ();

    logic     capture; // strobe, store rx data
    logic     resolve; // high for the whole RESOLVE state
    logic     clear;   // high while sequencer idles
    verdict_e verdict; // comb. from stored result
    logic     retried; // reversal already applied once

    modport seq (
        output capture, resolve, clear,
        input  verdict, retried
    );

    modport eval (
        input  capture, resolve, clear,
        output verdict, retried
    );

endinterface

//--- logic/reversal_mb_seq.sv
`timescale 1ns/10ps

module reversal_mb_seq import reversal_mb_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_reversal_en,      // level, from the link state machine
    input  logic        i_rx_msg_valid,
    input  sb_msg_e     i_rx_msg,
    input  logic        i_tx_busy_fall,
    input  logic        i_rx_wrapper_valid,
    input  logic        i_pattern_finished,
    output logic        o_send,             // one cycle, to sb_tx_hold
    output sb_msg_e     o_send_msg,
    output pg_cw_e      o_pg_cw,
    output logic        o_done,
    output logic        o_stop_timeout,     // one cycle pulse
    lane_eval_if.seq    ev
);

    seq_state_e state_q;
    seq_state_e state_d;
    logic       repeat_q;   // partner asked to repeat after its reversal
    logic       state_chg;

    // received message decodes, only meaningful with valid
    logic got_init_req;
    logic got_init_resp;
    logic got_clear_req;
    logic got_clear_resp;
    logic got_result_resp;
    logic got_done_resp;
    logic partner_release; // busy fall while wrapper answers the partner

    assign got_init_req    = i_rx_msg_valid && (i_rx_msg == MSG_INIT_REQ);
    assign got_init_resp   = i_rx_msg_valid && (i_rx_msg == MSG_INIT_RESP);
    assign got_clear_req   = i_rx_msg_valid && (i_rx_msg == MSG_CLEAR_ERROR_REQ);
    assign got_clear_resp  = i_rx_msg_valid && (i_rx_msg == MSG_CLEAR_ERROR_RESP);
    assign got_result_resp = i_rx_msg_valid && (i_rx_msg == MSG_RESULT_RESP);
    assign got_done_resp   = i_rx_msg_valid && (i_rx_msg == MSG_DONE_RESP);
    assign partner_release = i_tx_busy_fall && i_rx_wrapper_valid;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q; // hold by default
        if (!i_reversal_en) begin
            state_d = IDLE; // enable drop wins from any state
        end else begin
            case (state_q)
                IDLE: begin
                    if (got_init_req) begin
                        state_d = WAIT_PARTNER; // partner started first
                    end else begin
                        state_d = INIT_REQ;
                    end
                end
                WAIT_PARTNER: begin
                    if (partner_release) begin
                        state_d = repeat_q ? CLEAR_REQ : INIT_REQ;
                    end
                end
                INIT_REQ:     if (got_init_resp)      state_d = CLEAR_REQ;
                CLEAR_REQ:    if (got_clear_resp)     state_d = SEND_PATTERN;
                SEND_PATTERN: if (i_pattern_finished) state_d = RESULT_REQ;
                RESULT_REQ:   if (got_result_resp)    state_d = RESOLVE;
                RESOLVE: begin
                    if (ev.verdict == V_PASS) begin
                        state_d = DONE_REQ;
                    end else if (ev.verdict == V_RETRY && !ev.retried) begin
                        state_d = CLEAR_REQ; // one reversal attempt per run
                    end
                    // V_FAIL parks here until the enable drops
                end
                DONE_REQ: begin
                    if (got_clear_req) begin
                        state_d = WAIT_PARTNER; // partner repeats after reversal
                    end else if (got_done_resp) begin
                        state_d = FINISHED;
                    end
                end
                FINISHED: state_d = FINISHED;
                default:  state_d = IDLE;
            endcase
        end
    end

    assign state_chg = (state_d != state_q);

    // requests go out on entry into the matching state
    always_comb begin
        o_send     = 1'b0;
        o_send_msg = MSG_NONE;
        if (state_chg) begin
            case (state_d)
                INIT_REQ: begin
                    o_send     = 1'b1;
                    o_send_msg = MSG_INIT_REQ;
                end
                CLEAR_REQ: begin
                    o_send     = 1'b1;
                    o_send_msg = MSG_CLEAR_ERROR_REQ;
                end
                RESULT_REQ: begin
                    o_send     = 1'b1;
                    o_send_msg = MSG_RESULT_REQ;
                end
                DONE_REQ: begin
                    o_send     = 1'b1;
                    o_send_msg = MSG_DONE_REQ;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pg_cw        <= PG_IDLE;
            o_done         <= 1'b0;
            o_stop_timeout <= 1'b0;
            repeat_q       <= 1'b0;
        end else begin
            // partner clear_error_req during done_req
            o_stop_timeout <= (state_q == DONE_REQ) && (state_d == WAIT_PARTNER);
            if (state_d == IDLE) begin
                o_pg_cw  <= PG_IDLE;
                o_done   <= 1'b0;
                repeat_q <= 1'b0;
            end else if (state_chg) begin
                case (state_d)
                    CLEAR_REQ:    o_pg_cw <= PG_CLEAR_LFSR;
                    SEND_PATTERN: o_pg_cw <= PG_PERLANE_ID;
                    RESULT_REQ:   o_pg_cw <= PG_IDLE;   // pattern done
                    FINISHED:     o_done  <= 1'b1;
                    WAIT_PARTNER: repeat_q <= (state_q == DONE_REQ);
                    default: ;
                endcase
            end
        end
    end

    // evaluator controls
    assign ev.capture = (state_q == RESULT_REQ) && (state_d == RESOLVE);
    assign ev.resolve = (state_q == RESOLVE);
    assign ev.clear   = (state_q == IDLE);

endmodule

//--- logic/lane_result_eval.sv
`timescale 1ns/10ps
`include "reversal_mb_cfg.svh"

module lane_result_eval import reversal_mb_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_ltsm_in_reset,   // training restart drops the reversal
    input  logic [`REVMB_LANES-1:0] i_rx_data,         // per-lane pass bits from result_resp
    lane_eval_if.eval               ev,
    output logic                    o_apply_reversal,
    output logic                    o_train_error_req,
    output logic                    o_repeating
);

    logic [`REVMB_LANES-1:0] result_q;   // last captured result
    logic [`REVMB_CNT_W-1:0] match_cnt;
    logic                    retried_q;
    logic                    pass;

    // result word taken on the capture strobe
    always_ff @(posedge i_clk) begin
        if (ev.capture) begin
            result_q <= i_rx_data;
        end
    end

    // popcount of matching lanes
    always_comb begin
        match_cnt = '0;
        for (int i = 0; i < `REVMB_LANES; i++) begin
            match_cnt = match_cnt + `REVMB_CNT_W'(result_q[i]);
        end
    end

    assign pass = (match_cnt > `REVMB_CNT_W'(`REVMB_PASS_LANES));

    always_comb begin
        if (pass) begin
            ev.verdict = V_PASS;
        end else if (!retried_q) begin
            ev.verdict = V_RETRY; // first miss tries reversed lanes
        end else begin
            ev.verdict = V_FAIL;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            retried_q         <= 1'b0;
            o_train_error_req <= 1'b0;
        end else if (ev.clear) begin
            retried_q         <= 1'b0;
            o_train_error_req <= 1'b0;
        end else if (ev.resolve && ev.verdict == V_RETRY) begin
            retried_q <= 1'b1;
        end else if (ev.resolve && ev.verdict == V_FAIL) begin
            o_train_error_req <= 1'b1; // reversal did not help either
        end
    end

    // survives IDLE and stays applied for the rest of training
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_apply_reversal <= 1'b0;
        end else if (i_ltsm_in_reset) begin
            o_apply_reversal <= 1'b0;
        end else if (ev.resolve && ev.verdict == V_RETRY) begin
            o_apply_reversal <= 1'b1;
        end else if (ev.resolve && ev.verdict == V_FAIL) begin
            o_apply_reversal <= 1'b0;
        end
    end

    assign ev.retried  = retried_q;
    assign o_repeating = retried_q;

endmodule

//--- logic/sb_tx_hold.sv
`timescale 1ns/10ps

module sb_tx_hold import reversal_mb_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_send,             // one cycle strobe from sequencer
    input  sb_msg_e i_send_msg,
    input  logic    i_tx_busy_fall,     // sideband tx finished a message
    input  logic    i_rx_wrapper_valid, // busy fall belongs to a wrapper response
    output sb_msg_e o_tx_msg,
    output logic    o_tx_valid
);

    logic release_tx;

    // our own request left the transmitter
    assign release_tx = i_tx_busy_fall && !i_rx_wrapper_valid;

    // message stays put until the next send
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tx_msg <= MSG_NONE;
        end else if (i_send) begin
            o_tx_msg <= i_send_msg;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tx_valid <= 1'b0;
        end else if (i_send) begin
            o_tx_valid <= 1'b1; // new send overrides a pending one
        end else if (release_tx) begin
            o_tx_valid <= 1'b0;
        end
        // busy held means back-pressure, keep valid
    end

endmodule

//--- logic/reversal_mb_top.sv
`timescale 1ns/10ps
`include "reversal_mb_cfg.svh"

module reversal_mb_top import reversal_mb_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    // link state machine
    input  logic                    i_reversal_en,
    input  logic                    i_ltsm_in_reset,

    // sideband receive
    input  logic                    i_rx_msg_valid,
    input  logic [`REVMB_MSG_W-1:0] i_rx_msg,      // decoded code
    input  logic [`REVMB_LANES-1:0] i_rx_data,     // result_resp payload

    // sideband transmit
    input  logic                    i_tx_busy_fall,
    input  logic                    i_rx_wrapper_valid,

    // pattern generator
    input  logic                    i_pattern_finished,

    output logic [`REVMB_MSG_W-1:0] o_tx_msg,
    output logic                    o_tx_valid,
    output logic                    o_stop_timeout, // to sideband timeout counter
    output logic                    o_done,
    output logic                    o_train_error_req,
    output logic [1:0]              o_pg_cw,
    output logic                    o_apply_reversal,
    output logic                    o_repeating     // to wrapper
);

    logic    send;
    sb_msg_e send_msg;
    sb_msg_e tx_msg;
    pg_cw_e  pg_cw;

    lane_eval_if ev ();

    reversal_mb_seq u_seq (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_reversal_en      (i_reversal_en),
        .i_rx_msg_valid     (i_rx_msg_valid),
        .i_rx_msg           (sb_msg_e'(i_rx_msg)),
        .i_tx_busy_fall     (i_tx_busy_fall),
        .i_rx_wrapper_valid (i_rx_wrapper_valid),
        .i_pattern_finished (i_pattern_finished),
        .o_send             (send),
        .o_send_msg         (send_msg),
        .o_pg_cw            (pg_cw),
        .o_done             (o_done),
        .o_stop_timeout     (o_stop_timeout),
        .ev                 (ev.seq)
    );

    lane_result_eval u_eval (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_ltsm_in_reset   (i_ltsm_in_reset),
        .i_rx_data         (i_rx_data),
        .ev                (ev.eval),
        .o_apply_reversal  (o_apply_reversal),
        .o_train_error_req (o_train_error_req),
        .o_repeating       (o_repeating)
    );

    sb_tx_hold u_tx_hold (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_send             (send),
        .i_send_msg         (send_msg),
        .i_tx_busy_fall     (i_tx_busy_fall),
        .i_rx_wrapper_valid (i_rx_wrapper_valid),
        .o_tx_msg           (tx_msg),
        .o_tx_valid         (o_tx_valid)
    );

    // enum to plain bits at the boundary
    assign o_tx_msg = tx_msg;
    assign o_pg_cw  = pg_cw;

endmodule

//--- tests/reversal_mb_tests.svh
`ifndef REVERSAL_MB_TESTS_SVH
`define REVERSAL_MB_TESTS_SVH

task automatic expect_tx(input sb_msg_e msg, input string what);
    check(o_tx_valid, 1'b1, {what, ", valid"});
    check(o_tx_msg, msg, {what, ", code"});
endtask

// busy fall that belongs to a wrapper response
task automatic partner_release();
    i_tx_busy_fall     = 1'b1;
    i_rx_wrapper_valid = 1'b1;
    step();
    i_tx_busy_fall     = 1'b0;
    i_rx_wrapper_valid = 1'b0;
endtask

// two edges in idle so the evaluator flags clear too
task automatic idle_link();
    i_reversal_en = 1'b0;
    step();
    step();
    check(o_pg_cw, PG_IDLE, "pg_cw in idle");
    check(o_done, 1'b0, "done in idle");
    check(o_stop_timeout, 1'b0, "stop_timeout in idle");
    check(o_train_error_req, 1'b0, "train error in idle");
    check(o_repeating, 1'b0, "repeating in idle");
endtask

task automatic start_run();
    i_reversal_en = 1'b1;
    step();
    expect_tx(MSG_INIT_REQ, "one cycle after enable");
    serve_request(MSG_INIT_REQ);
    send_rx(MSG_INIT_RESP, '0);
endtask

// clear, pattern and result handshakes up to the resolve edge
task automatic run_to_result(input bit want_pass);
    logic [`REVMB_LANES-1:0] word;
    draw_word(want_pass, word);
    serve_request(MSG_CLEAR_ERROR_REQ);
    check(o_pg_cw, PG_CLEAR_LFSR, "pg_cw during clear");
    send_rx(MSG_CLEAR_ERROR_RESP, '0);
    check(o_pg_cw, PG_PERLANE_ID, "pg_cw during pattern");
    i_pattern_finished = 1'b1;
    step();
    i_pattern_finished = 1'b0;
    check(o_pg_cw, PG_IDLE, "pg_cw after pattern");
    serve_request(MSG_RESULT_REQ);
    send_rx(MSG_RESULT_RESP, word); // capture edge
    step();                         // resolve edge
endtask

task automatic finish_run();
    serve_request(MSG_DONE_REQ);
    send_rx(MSG_DONE_RESP, '0);
    wait_done();
endtask

task automatic reset_and_pass();
    check({o_tx_valid, o_done, o_stop_timeout, o_train_error_req}, '0, "flags after reset");
    check({o_repeating, o_apply_reversal, o_pg_cw}, '0, "reversal and pg_cw after reset");
    start_run();
    run_to_result(1'b1);
    expect_tx(MSG_DONE_REQ, "after a passing result");
    finish_run();
    check(o_apply_reversal, 1'b0, "no reversal on a clean pass");
endtask

task automatic retry_then_pass();
    idle_link();
    start_run();
    run_to_result(1'b0);
    expect_tx(MSG_CLEAR_ERROR_REQ, "resend after a failing result");
    check(o_apply_reversal, 1'b1, "reversal on retry");
    check(o_repeating, 1'b1, "repeating on retry");
    run_to_result(1'b1);
    expect_tx(MSG_DONE_REQ, "pass after reversal");
    finish_run();
    check(o_apply_reversal, 1'b1, "reversal kept after pass");
endtask

task automatic retry_then_fail();
    idle_link();
    start_run();
    run_to_result(1'b0);
    expect_tx(MSG_CLEAR_ERROR_REQ, "resend before the second try");
    run_to_result(1'b0);
    check(o_train_error_req, 1'b1, "train error after two misses");
    check(o_apply_reversal, 1'b0, "reversal dropped on fail");
    repeat (8) begin
        step();
        check(o_tx_valid, 1'b0, "no request after a failed retry");
    end
endtask

task automatic partner_paths();
    idle_link();
    i_reversal_en = 1'b1;
    send_rx(MSG_INIT_REQ, '0); // partner starts in the same cycle
    repeat (4) begin
        check(o_tx_valid, 1'b0, "valid while partner owns init");
        step();
    end
    partner_release();
    expect_tx(MSG_INIT_REQ, "init after partner release");
    serve_request(MSG_INIT_REQ);
    send_rx(MSG_INIT_RESP, '0);
    run_to_result(1'b1);
    serve_request(MSG_DONE_REQ);
    send_rx(MSG_CLEAR_ERROR_REQ, '0); // partner repeats after its reversal
    check(o_stop_timeout, 1'b1, "stop_timeout on partner repeat");
    step();
    check(o_stop_timeout, 1'b0, "stop_timeout width");
    check(o_tx_valid, 1'b0, "valid while partner repeats");
    partner_release();
    expect_tx(MSG_CLEAR_ERROR_REQ, "clear after partner repeat");
    run_to_result(1'b1);
    finish_run();
endtask

task automatic release_and_exits();
    idle_link();
    i_reversal_en = 1'b1;
    step();
    repeat (3) step(); // transmitter holds busy
    expect_tx(MSG_INIT_REQ, "held under back-pressure");
    partner_release();
    expect_tx(MSG_INIT_REQ, "kept on a wrapper busy fall");
    serve_request(MSG_INIT_REQ);
    send_rx(MSG_INIT_RESP, '0);
    run_to_result(1'b1);
    finish_run();
    i_reversal_en = 1'b0;
    step();
    check(o_done, 1'b0, "done after enable drop");
    start_run();
    run_to_result(1'b0);
    check(o_apply_reversal, 1'b1, "reversal before the exit");
    serve_request(MSG_CLEAR_ERROR_REQ);
    send_rx(MSG_CLEAR_ERROR_RESP, '0);
    check(o_pg_cw, PG_PERLANE_ID, "pg_cw before the exit");
    i_reversal_en = 1'b0; // drop mid pattern
    step();
    check(o_pg_cw, PG_IDLE, "pg_cw after enable drop");
    step(); // evaluator clear acts on this edge
    check(o_apply_reversal, 1'b1, "reversal survives idle");
    i_ltsm_in_reset = 1'b1;
    step();
    i_ltsm_in_reset = 1'b0;
    check(o_apply_reversal, 1'b0, "reversal after training reset");
endtask

`endif

//--- tests/reversal_mb_tb.sv
`timescale 1ns/10ps
`include "reversal_mb_cfg.svh"

module reversal_mb_tb import reversal_mb_pkg::*; ();

    localparam int WAIT_LIMIT = 200; // cycles allowed per wait

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_reversal_en;
    logic                    i_ltsm_in_reset;
    logic                    i_rx_msg_valid;
    logic [`REVMB_MSG_W-1:0] i_rx_msg;
    logic [`REVMB_LANES-1:0] i_rx_data;
    logic                    i_tx_busy_fall;
    logic                    i_rx_wrapper_valid;
    logic                    i_pattern_finished;
    logic [`REVMB_MSG_W-1:0] o_tx_msg;
    logic                    o_tx_valid;
    logic                    o_stop_timeout;
    logic                    o_done;
    logic                    o_train_error_req;
    logic [1:0]              o_pg_cw;
    logic                    o_apply_reversal;
    logic                    o_repeating;
    logic [31:0]             lfsr_q; // result word source

    reversal_mb_top uut (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk; // 40 ns period
    end

    // one clock, inputs change 2 ns after the edge, outputs settled by then
    task automatic step();
        @(posedge i_clk);
        #2;
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic give_up(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic wait_valid(input string what);
        int n;
        n = 0;
        while (!o_tx_valid) begin
            step();
            n++;
            if (n > WAIT_LIMIT) give_up({"timed out waiting for o_tx_valid with ", what});
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!o_done) begin
            step();
            n++;
            if (n > WAIT_LIMIT) give_up("timed out waiting for o_done");
        end
    endtask

    // galois form, taps x^32 x^22 x^2 x 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per lane bit, redraw until the word lands on the wanted side
    task automatic draw_word(input bit want_pass, output logic [`REVMB_LANES-1:0] word);
        int ones;
        for (int tries = 0; tries < 64; tries++) begin
            ones = 0;
            for (int i = 0; i < `REVMB_LANES; i++) begin
                word[i] = lfsr_q[0];
                ones    = ones + lfsr_q[0]; // expected match count
                lfsr_q  = lfsr_next(lfsr_q);
            end
            if ((ones > `REVMB_PASS_LANES) == want_pass) return;
        end
        give_up("the lfsr produced no usable result word");
    endtask

    // checks the pending request, then the transmitter takes it
    task automatic serve_request(input sb_msg_e exp_msg);
        wait_valid(exp_msg.name());
        check(o_tx_msg, exp_msg, "request code");
        i_tx_busy_fall = 1'b1; // own message, wrapper quiet
        step();
        i_tx_busy_fall = 1'b0;
        check(o_tx_valid, 1'b0, "valid after busy fall");
    endtask

    task automatic send_rx(input sb_msg_e msg, input logic [`REVMB_LANES-1:0] data);
        i_rx_msg_valid = 1'b1;
        i_rx_msg       = msg;
        i_rx_data      = data;
        step();
        i_rx_msg_valid = 1'b0;
        i_rx_msg       = MSG_NONE;
    endtask

    `include "reversal_mb_tests.svh"

    initial begin
        i_rst_n            = 1'b0;
        i_reversal_en      = 1'b0;
        i_ltsm_in_reset    = 1'b0;
        i_rx_msg_valid     = 1'b0;
        i_rx_msg           = MSG_NONE;
        i_rx_data          = '0;
        i_tx_busy_fall     = 1'b0;
        i_rx_wrapper_valid = 1'b0;
        i_pattern_finished = 1'b0;
        lfsr_q             = 32'he9b3;
        repeat (2) @(posedge i_clk);
        #2 i_rst_n = 1'b1;
        reset_and_pass();
        retry_then_pass();
        retry_then_fail();
        partner_paths();
        release_and_exits();
        $display("test passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
+incdir+tests
logic/reversal_mb_pkg.sv
logic/lane_eval_if.sv
logic/reversal_mb_seq.sv
logic/lane_result_eval.sv
logic/sb_tx_hold.sv
logic/reversal_mb_top.sv
tests/reversal_mb_tb.sv

//--- Bender.yml
package:
  name: reversal_mb

sources:
  - include_dirs:
      - logic
    files:
      - logic/reversal_mb_pkg.sv
      - logic/lane_eval_if.sv
      - logic/reversal_mb_seq.sv
      - logic/lane_result_eval.sv
      - logic/sb_tx_hold.sv
      - logic/reversal_mb_top.sv
  - target: test
    include_dirs:
      - logic
      - tests
    files:
      - tests/reversal_mb_tb.sv
